// File: stepper_params.svh
`ifndef STEPPER_PARAMS_SVH
`define STEPPER_PARAMS_SVH

// Field widths
`define STEPPER_PHASE_W      8
`define STEPPER_OFFTIME_W    10
`define STEPPER_SHORT_W      8
`define STEPPER_VREF_W       8
`define STEPPER_APB_ADDR_W   8
`define STEPPER_APB_DATA_W   32

// Register byte offsets
`define STEPPER_REG_CTRL       8'h00
`define STEPPER_REG_FASTDECAY  8'h04
`define STEPPER_REG_OFFTIME    8'h08
`define STEPPER_REG_BLANK      8'h0C
`define STEPPER_REG_MINON      8'h10
`define STEPPER_REG_STATUS     8'h14

// CTRL and STATUS bit positions
`define STEPPER_CTRL_ENABLE_BIT    0
`define STEPPER_CTRL_INV_HS_BIT    1
`define STEPPER_CTRL_INV_LS_BIT    2
`define STEPPER_STATUS_FAULTN_BIT  0
`define STEPPER_STATUS_PHASE_LSB   8

// Reset values
`define STEPPER_CTRL_RST       3'b000
`define STEPPER_FASTDECAY_RST  10'd706
`define STEPPER_OFFTIME_RST    10'd900
`define STEPPER_BLANK_RST      8'd40
`define STEPPER_MINON_RST      8'd30

// Full-scale DAC reference
`define STEPPER_SINE_PEAK      8'd255

`endif

// File: stepper_pkg.sv
package stepper_pkg;

  `include "stepper_params.svh"

  // Microstep position, 256 microsteps per electrical cycle
  typedef logic [`STEPPER_PHASE_W-1:0] phase_t;

  // Off timer and fast-decay threshold
  typedef logic [`STEPPER_OFFTIME_W-1:0] off_time_t;

  // Blank and minimum-on timers
  typedef logic [`STEPPER_SHORT_W-1:0] short_time_t;

  // Current DAC reference level
  typedef logic [`STEPPER_VREF_W-1:0] vref_t;

  // APB address and data
  typedef logic [`STEPPER_APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [`STEPPER_APB_DATA_W-1:0] apb_data_t;

  // Chopper timer states
  // Minimum-on count runs alongside BLANK and ON
  typedef enum logic [1:0] {
    CHOP_ON,
    CHOP_OFF,
    CHOP_BLANK
  } chop_state_e;

endpackage

// File: stepper_apb_regs.sv
`timescale 1ns/10ps
`include "stepper_params.svh"

module stepper_apb_regs
  import stepper_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  apb_addr_t   paddr,
  input  apb_data_t   pwdata,
  output apb_data_t   prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        cfg_enable,
  output logic        cfg_invert_highside,
  output logic        cfg_invert_lowside,
  output off_time_t   cfg_fastdecay_threshold,
  output off_time_t   cfg_off_time,
  output short_time_t cfg_blank_time,
  output short_time_t cfg_min_on_time,
  input  phase_t      phase_ct,
  input  logic        faultn
);

  logic      access;
  logic      addr_hit;
  logic      wr_en;
  apb_data_t status;

  // Zero wait states
  assign pready = 1'b1;
  assign access = psel && penable;

  // Status word from live counter and fault latch
  always_comb begin
    status = '0;
    status[`STEPPER_STATUS_FAULTN_BIT] = faultn;
    status[`STEPPER_STATUS_PHASE_LSB +: `STEPPER_PHASE_W] = phase_ct;
  end

  // Read mux and address decode
  always_comb begin
    prdata   = '0;
    addr_hit = 1'b1;
    case (paddr)
      `STEPPER_REG_CTRL: begin
        prdata[`STEPPER_CTRL_ENABLE_BIT] = cfg_enable;
        prdata[`STEPPER_CTRL_INV_HS_BIT] = cfg_invert_highside;
        prdata[`STEPPER_CTRL_INV_LS_BIT] = cfg_invert_lowside;
      end
      `STEPPER_REG_FASTDECAY: prdata[`STEPPER_OFFTIME_W-1:0] = cfg_fastdecay_threshold;
      `STEPPER_REG_OFFTIME:   prdata[`STEPPER_OFFTIME_W-1:0] = cfg_off_time;
      `STEPPER_REG_BLANK:     prdata[`STEPPER_SHORT_W-1:0] = cfg_blank_time;
      `STEPPER_REG_MINON:     prdata[`STEPPER_SHORT_W-1:0] = cfg_min_on_time;
      `STEPPER_REG_STATUS:    prdata = status;
      default:                addr_hit = 1'b0;
    endcase
  end

  // STATUS is read-only
  assign pslverr = access && (!addr_hit || (pwrite && paddr == `STEPPER_REG_STATUS));
  assign wr_en   = access && pwrite && addr_hit;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      {cfg_invert_lowside, cfg_invert_highside, cfg_enable} <= `STEPPER_CTRL_RST;
      cfg_fastdecay_threshold <= `STEPPER_FASTDECAY_RST;
      cfg_off_time            <= `STEPPER_OFFTIME_RST;
      cfg_blank_time          <= `STEPPER_BLANK_RST;
      cfg_min_on_time         <= `STEPPER_MINON_RST;
    end else if (wr_en) begin
      case (paddr)
        `STEPPER_REG_CTRL: begin
          cfg_enable          <= pwdata[`STEPPER_CTRL_ENABLE_BIT];
          cfg_invert_highside <= pwdata[`STEPPER_CTRL_INV_HS_BIT];
          cfg_invert_lowside  <= pwdata[`STEPPER_CTRL_INV_LS_BIT];
        end
        `STEPPER_REG_FASTDECAY: cfg_fastdecay_threshold <= pwdata[`STEPPER_OFFTIME_W-1:0];
        `STEPPER_REG_OFFTIME:   cfg_off_time <= pwdata[`STEPPER_OFFTIME_W-1:0];
        `STEPPER_REG_BLANK:     cfg_blank_time <= pwdata[`STEPPER_SHORT_W-1:0];
        `STEPPER_REG_MINON:     cfg_min_on_time <= pwdata[`STEPPER_SHORT_W-1:0];
        default: ;
      endcase
    end
  end

  // Access phase must follow a setup phase
  a_penable_after_psel: assert property (
    @(posedge clk) disable iff (!resetn)
    penable |-> $past(psel)
  );

endmodule

// File: phase_sequencer.sv
`timescale 1ns/10ps
`include "stepper_params.svh"

module phase_sequencer
  import stepper_pkg::*;
(
  input  logic   clk,
  input  logic   resetn,
  input  phase_t phase_ct,
  output logic   s1,
  output logic   s2,
  output logic   s3,
  output logic   s4,
  output vref_t  vref_a,
  output vref_t  vref_b
);

  // First quarter of |sin|, 64 points scaled to 255
  localparam vref_t SINE_QW [64] = '{
    8'd0,   8'd6,   8'd13,  8'd19,  8'd25,  8'd31,  8'd37,  8'd44,
    8'd50,  8'd56,  8'd62,  8'd68,  8'd74,  8'd80,  8'd86,  8'd92,
    8'd98,  8'd103, 8'd109, 8'd115, 8'd120, 8'd126, 8'd131, 8'd136,
    8'd142, 8'd147, 8'd152, 8'd157, 8'd162, 8'd167, 8'd171, 8'd176,
    8'd180, 8'd185, 8'd189, 8'd193, 8'd197, 8'd201, 8'd205, 8'd208,
    8'd212, 8'd215, 8'd219, 8'd222, 8'd225, 8'd228, 8'd231, 8'd233,
    8'd236, 8'd238, 8'd240, 8'd242, 8'd244, 8'd246, 8'd247, 8'd249,
    8'd250, 8'd251, 8'd252, 8'd253, 8'd254, 8'd254, 8'd255, 8'd255
  };

  // Odd quadrants read the table mirrored; index 64 is the peak
  function automatic vref_t sine_mag(input phase_t p);
    logic [5:0] idx;
    idx = p[5:0];
    if (!p[6])
      return SINE_QW[idx];
    else if (idx == 6'd0)
      return `STEPPER_SINE_PEAK;
    else
      return SINE_QW[6'd0 - idx];
  endfunction

  phase_t cos_phase;
  logic   coil_a_pos;
  logic   coil_b_pos;

  // Cosine is sine a quarter cycle ahead
  assign cos_phase  = phase_ct + 8'd64;
  assign coil_a_pos = ~phase_ct[7];
  assign coil_b_pos = phase_ct[7] ^ phase_ct[6];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      s1     <= 1'b1;
      s2     <= 1'b0;
      s3     <= 1'b0;
      s4     <= 1'b1;
      vref_a <= `STEPPER_SINE_PEAK;
      vref_b <= '0;
    end else begin
      s1     <= coil_a_pos;
      s2     <= ~coil_a_pos;
      s3     <= coil_b_pos;
      s4     <= ~coil_b_pos;
      vref_a <= sine_mag(cos_phase);
      vref_b <= sine_mag(phase_ct);
    end
  end

  a_polarity_pairs: assert property (
    @(posedge clk) disable iff (!resetn)
    (s1 != s2) && (s3 != s4)
  );

endmodule

// File: chopper_timer.sv
`timescale 1ns/10ps

module chopper_timer
  import stepper_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic        offtimer_en,
  input  off_time_t   cfg_off_time,
  input  short_time_t cfg_blank_time,
  input  short_time_t cfg_min_on_time,
  output off_time_t   off_timer,
  output short_time_t blank_timer,
  output short_time_t minimum_on_timer
);

  chop_state_e state;
  logic        off_done;

  // Last off cycle, blank and minimum-on load here
  assign off_done = (state == CHOP_OFF) && (off_timer <= off_time_t'(1));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state       <= CHOP_ON;
      off_timer   <= '0;
      blank_timer <= '0;
    end else begin
      case (state)
        CHOP_ON: begin
          if (offtimer_en) begin
            off_timer <= cfg_off_time;
            state     <= CHOP_OFF;
          end
        end
        CHOP_OFF: begin
          if (off_done) begin
            off_timer   <= '0;
            blank_timer <= cfg_blank_time;
            state       <= CHOP_BLANK;
          end else begin
            off_timer <= off_timer - 1'b1;
          end
        end
        CHOP_BLANK: begin
          // Comparator is ignored until blanking ends
          if (blank_timer > short_time_t'(1)) begin
            blank_timer <= blank_timer - 1'b1;
          end else begin
            blank_timer <= '0;
            state       <= CHOP_ON;
          end
        end
        default: state <= CHOP_ON;
      endcase
    end
  end

  // Minimum-on count, free running after load
  always_ff @(posedge clk) begin
    if (!resetn)
      minimum_on_timer <= '0;
    else if (off_done)
      minimum_on_timer <= cfg_min_on_time;
    else if (minimum_on_timer != '0)
      minimum_on_timer <= minimum_on_timer - 1'b1;
  end

  a_off_blank_exclusive: assert property (
    @(posedge clk) disable iff (!resetn)
    !((off_timer != '0) && (blank_timer != '0))
  );

endmodule

// File: microstepper_control.sv
`timescale 1ns/10ps

module microstepper_control
  import stepper_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  logic        step,
  input  logic        dir,
  input  logic        enable_in,
  input  logic        config_invert_highside,
  input  logic        config_invert_lowside,
  input  off_time_t   config_fastdecay_threshold,
  input  logic        analog_cmp1,
  input  logic        analog_cmp2,
  input  logic        s1,
  input  logic        s2,
  input  logic        s3,
  input  logic        s4,
  output phase_t      phase_ct,
  output logic        faultn,
  output logic        offtimer_en0,
  output logic        offtimer_en1,
  input  off_time_t   off_timer0,
  input  off_time_t   off_timer1,
  input  short_time_t blank_timer0,
  input  short_time_t blank_timer1,
  input  short_time_t minimum_on_timer0,
  input  short_time_t minimum_on_timer1,
  output logic        phase_a1_l_out,
  output logic        phase_a2_l_out,
  output logic        phase_b1_l_out,
  output logic        phase_b2_l_out,
  output logic        phase_a1_h_out,
  output logic        phase_a2_h_out,
  output logic        phase_b1_h_out,
  output logic        phase_b2_h_out
);

  logic [1:0] step_sync;
  logic [1:0] dir_sync;
  logic       step_prev;
  logic       step_rise;
  logic       enable;
  logic       fault_a, fault_b;
  logic       fast_a, fast_b, slow_a, slow_b;
  logic       a1_h, a2_h, b1_h, b2_h;
  logic       a1_l, a2_l, b1_l, b2_l;
  logic       hs_allow, ls_force;

  // Two-stage pin synchronizers plus edge history
  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_sync <= '0;
      dir_sync  <= '0;
      step_prev <= 1'b0;
      enable    <= 1'b0;
    end else begin
      step_sync <= {step_sync[0], step};
      dir_sync  <= {dir_sync[0], dir};
      step_prev <= step_sync[1];
      enable    <= enable_in;
    end
  end

  assign step_rise = step_sync[1] && !step_prev;

  always_ff @(posedge clk) begin
    if (!resetn)
      phase_ct <= '0;
    else if (step_rise)
      phase_ct <= dir_sync[1] ? phase_ct + 1'b1 : phase_ct - 1'b1;
  end

  // Off period started while minimum on time still running
  assign fault_a = (off_timer0 != '0) && (minimum_on_timer0 != '0);
  assign fault_b = (off_timer1 != '0) && (minimum_on_timer1 != '0);

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!resetn)
      faultn <= 1'b1;
    else if (faultn)
      faultn <= !((fault_a || fault_b) && enable);
  end

  // Start of off time on a comparator trip
  assign offtimer_en0 = analog_cmp1 && (blank_timer0 == '0) && (off_timer0 == '0);
  assign offtimer_en1 = analog_cmp2 && (blank_timer1 == '0) && (off_timer1 == '0);

  // Fast decay is the early part of the off time
  assign fast_a = (off_timer0 != '0) && (off_timer0 >= config_fastdecay_threshold);
  assign fast_b = (off_timer1 != '0) && (off_timer1 >= config_fastdecay_threshold);
  assign slow_a = (off_timer0 != '0) && !fast_a;
  assign slow_b = (off_timer1 != '0) && !fast_b;

  // High sides follow polarity, reversed in fast decay, off in slow decay
  assign a1_h = !slow_a && (fast_a ? !s1 : s1);
  assign a2_h = !slow_a && (fast_a ? !s2 : s2);
  assign b1_h = !slow_b && (fast_b ? !s3 : s3);
  assign b2_h = !slow_b && (fast_b ? !s4 : s4);

  // Low sides are the complement, both on in slow decay
  assign a1_l = slow_a || (fast_a ? s1 : !s1);
  assign a2_l = slow_a || (fast_a ? s2 : !s2);
  assign b1_l = slow_b || (fast_b ? s3 : !s3);
  assign b2_l = slow_b || (fast_b ? s4 : !s4);

  // Disabled or faulted bridges brake on the low sides
  assign hs_allow = enable && faultn;
  assign ls_force = !enable || !faultn;

  assign phase_a1_h_out = config_invert_highside ^ (a1_h && hs_allow);
  assign phase_a2_h_out = config_invert_highside ^ (a2_h && hs_allow);
  assign phase_b1_h_out = config_invert_highside ^ (b1_h && hs_allow);
  assign phase_b2_h_out = config_invert_highside ^ (b2_h && hs_allow);

  assign phase_a1_l_out = config_invert_lowside ^ (a1_l || ls_force);
  assign phase_a2_l_out = config_invert_lowside ^ (a2_l || ls_force);
  assign phase_b1_l_out = config_invert_lowside ^ (b1_l || ls_force);
  assign phase_b2_l_out = config_invert_lowside ^ (b2_l || ls_force);

  // Every leg always has one gate on, so no coil ever floats
  a_no_floating_leg: assert property (
    @(posedge clk) disable iff (!resetn)
    (a1_h || a1_l) && (a2_h || a2_l) && (b1_h || b1_l) && (b2_h || b2_l)
  );

endmodule

// File: stepper_top.sv
`timescale 1ns/10ps

module stepper_top
  import stepper_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  input  logic      step,
  input  logic      dir,
  input  logic      analog_cmp1,
  input  logic      analog_cmp2,
  output logic      phase_a1_l_out,
  output logic      phase_a2_l_out,
  output logic      phase_b1_l_out,
  output logic      phase_b2_l_out,
  output logic      phase_a1_h_out,
  output logic      phase_a2_h_out,
  output logic      phase_b1_h_out,
  output logic      phase_b2_h_out,
  output logic      faultn,
  output vref_t     vref_a,
  output vref_t     vref_b
);

  logic        cfg_enable;
  logic        cfg_invert_highside;
  logic        cfg_invert_lowside;
  off_time_t   cfg_fastdecay_threshold;
  off_time_t   cfg_off_time;
  short_time_t cfg_blank_time;
  short_time_t cfg_min_on_time;
  phase_t      phase_ct;
  logic        s1, s2, s3, s4;
  logic        offtimer_en0, offtimer_en1;
  off_time_t   off_timer0, off_timer1;
  short_time_t blank_timer0, blank_timer1;
  short_time_t minimum_on_timer0, minimum_on_timer1;

  stepper_apb_regs u_regs (
    .clk                     (clk),
    .resetn                  (resetn),
    .psel                    (psel),
    .penable                 (penable),
    .pwrite                  (pwrite),
    .paddr                   (paddr),
    .pwdata                  (pwdata),
    .prdata                  (prdata),
    .pready                  (pready),
    .pslverr                 (pslverr),
    .cfg_enable              (cfg_enable),
    .cfg_invert_highside     (cfg_invert_highside),
    .cfg_invert_lowside      (cfg_invert_lowside),
    .cfg_fastdecay_threshold (cfg_fastdecay_threshold),
    .cfg_off_time            (cfg_off_time),
    .cfg_blank_time          (cfg_blank_time),
    .cfg_min_on_time         (cfg_min_on_time),
    .phase_ct                (phase_ct),
    .faultn                  (faultn)
  );

  phase_sequencer u_seq (
    .clk      (clk),
    .resetn   (resetn),
    .phase_ct (phase_ct),
    .s1       (s1),
    .s2       (s2),
    .s3       (s3),
    .s4       (s4),
    .vref_a   (vref_a),
    .vref_b   (vref_b)
  );

  // Coil A timer
  chopper_timer chop_a (
    .clk              (clk),
    .resetn           (resetn),
    .offtimer_en      (offtimer_en0),
    .cfg_off_time     (cfg_off_time),
    .cfg_blank_time   (cfg_blank_time),
    .cfg_min_on_time  (cfg_min_on_time),
    .off_timer        (off_timer0),
    .blank_timer      (blank_timer0),
    .minimum_on_timer (minimum_on_timer0)
  );

  // Coil B timer
  chopper_timer chop_b (
    .clk              (clk),
    .resetn           (resetn),
    .offtimer_en      (offtimer_en1),
    .cfg_off_time     (cfg_off_time),
    .cfg_blank_time   (cfg_blank_time),
    .cfg_min_on_time  (cfg_min_on_time),
    .off_timer        (off_timer1),
    .blank_timer      (blank_timer1),
    .minimum_on_timer (minimum_on_timer1)
  );

  microstepper_control u_ctrl (
    .clk                        (clk),
    .resetn                     (resetn),
    .step                       (step),
    .dir                        (dir),
    .enable_in                  (cfg_enable),
    .config_invert_highside     (cfg_invert_highside),
    .config_invert_lowside      (cfg_invert_lowside),
    .config_fastdecay_threshold (cfg_fastdecay_threshold),
    .analog_cmp1                (analog_cmp1),
    .analog_cmp2                (analog_cmp2),
    .s1                         (s1),
    .s2                         (s2),
    .s3                         (s3),
    .s4                         (s4),
    .phase_ct                   (phase_ct),
    .faultn                     (faultn),
    .offtimer_en0               (offtimer_en0),
    .offtimer_en1               (offtimer_en1),
    .off_timer0                 (off_timer0),
    .off_timer1                 (off_timer1),
    .blank_timer0               (blank_timer0),
    .blank_timer1               (blank_timer1),
    .minimum_on_timer0          (minimum_on_timer0),
    .minimum_on_timer1          (minimum_on_timer1),
    .phase_a1_l_out             (phase_a1_l_out),
    .phase_a2_l_out             (phase_a2_l_out),
    .phase_b1_l_out             (phase_b1_l_out),
    .phase_b2_l_out             (phase_b2_l_out),
    .phase_a1_h_out             (phase_a1_h_out),
    .phase_a2_h_out             (phase_a2_h_out),
    .phase_b1_h_out             (phase_b1_h_out),
    .phase_b2_h_out             (phase_b2_h_out)
  );

endmodule

// File: tb_stepper.sv
`timescale 1ns/10ps
`include "stepper_params.svh"

module tb_stepper
  import stepper_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  // One step pulse plus its idle gap
  localparam int STEP_CYCLES = 11;
  // Worst case microsteps over all tests
  localparam int MAX_STEPS = 480;
  localparam int WATCHDOG_CYCLES = MAX_STEPS * STEP_CYCLES + 2500;

  // Coil A decay modes for the expected gate pattern
  localparam int DRIVE = 0;
  localparam int FAST = 1;
  localparam int SLOW = 2;

  logic      clk;
  logic      resetn;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      step;
  logic      dir;
  logic      analog_cmp1;
  logic      analog_cmp2;
  logic      phase_a1_l_out;
  logic      phase_a2_l_out;
  logic      phase_b1_l_out;
  logic      phase_b2_l_out;
  logic      phase_a1_h_out;
  logic      phase_a2_h_out;
  logic      phase_b1_h_out;
  logic      phase_b2_h_out;
  logic      faultn;
  vref_t     vref_a;
  vref_t     vref_b;
  phase_t    exp_phase;

  stepper_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on failure");
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("Watchdog timeout, the tests did not finish in time");
  end

  task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s is 0x%08h, expected 0x%08h",
                          $time, what, got, exp));
  endtask

  task automatic check_phase(input phase_t got, input phase_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_vref(input vref_t got, input vref_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_gates(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s gates are %08b, expected %08b",
                          $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  // Order is a1_h a2_h b1_h b2_h a1_l a2_l b1_l b2_l
  function automatic logic [7:0] read_gates();
    return {phase_a1_h_out, phase_a2_h_out, phase_b1_h_out, phase_b2_h_out,
            phase_a1_l_out, phase_a2_l_out, phase_b1_l_out, phase_b2_l_out};
  endfunction

  // Enabled, not inverted; coil B always in plain drive
  function automatic logic [7:0] expect_gates(input phase_t p, input int a_mode);
    logic       a_pos;
    logic       b_pos;
    logic [1:0] ah;
    logic [1:0] bh;
    logic [1:0] al;
    a_pos = (p[7:6] == 2'd0) || (p[7:6] == 2'd1);
    b_pos = (p[7:6] == 2'd1) || (p[7:6] == 2'd2);
    bh = {b_pos, !b_pos};
    if (a_mode == FAST)
      ah = {!a_pos, a_pos};
    else if (a_mode == SLOW)
      ah = 2'b00;
    else
      ah = {a_pos, !a_pos};
    al = (a_mode == SLOW) ? 2'b11 : ~ah;
    return {ah, bh, al, ~bh};
  endfunction

  task automatic apply_reset();
    resetn = 1'b0;
    repeat (5) @(negedge clk);
    resetn = 1'b1;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    @(negedge clk);
    psel = 1'b1;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    check_flag(pready, 1'b1, "pready");
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    @(negedge clk);
    psel = 1'b1;
    pwrite = 1'b0;
    paddr = addr;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    check_flag(pready, 1'b1, "pready");
    data = prdata;
    err = pslverr;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    logic err;
    apb_write(addr, data, err);
    check_flag(err, 1'b0, "pslverr on write");
  endtask

  task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
    logic err;
    apb_read(addr, data, err);
    check_flag(err, 1'b0, "pslverr on read");
  endtask

  task automatic write_readback(input apb_addr_t addr, input apb_data_t mask);
    apb_data_t val;
    apb_data_t data;
    val = $urandom();
    write_reg(addr, val);
    read_reg(addr, data);
    check_data(data, val & mask, $sformatf("readback of 0x%02h", addr));
  endtask

  task automatic read_status_check(input logic exp_faultn);
    apb_data_t data;
    read_reg(`STEPPER_REG_STATUS, data);
    check_phase(data[`STEPPER_STATUS_PHASE_LSB +: 8], exp_phase, "STATUS phase_ct");
    check_flag(data[`STEPPER_STATUS_FAULTN_BIT], exp_faultn, "STATUS faultn");
  endtask

  task automatic do_step(input logic up);
    @(negedge clk);
    dir = up;
    step = 1'b1;
    repeat (2) @(negedge clk);
    step = 1'b0;
    repeat (8) @(negedge clk);
    exp_phase = up ? exp_phase + 8'd1 : exp_phase - 8'd1;
  endtask

  // Shortest way round the electrical cycle
  task automatic move_to(input phase_t target);
    phase_t up_dist;
    up_dist = target - exp_phase;
    if (up_dist <= 8'd128)
      repeat (int'(up_dist)) do_step(1'b1);
    else
      repeat (256 - int'(up_dist)) do_step(1'b0);
  endtask

  task automatic check_drive(input string what);
    check_gates(read_gates(), expect_gates(exp_phase, DRIVE), what);
  endtask

  task automatic test_register_access();
    apb_data_t data;
    logic      err;
    read_reg(`STEPPER_REG_CTRL, data);
    check_data(data, 32'd0, "CTRL after reset");
    read_reg(`STEPPER_REG_FASTDECAY, data);
    check_data(data, 32'd706, "FASTDECAY after reset");
    read_reg(`STEPPER_REG_OFFTIME, data);
    check_data(data, 32'd900, "OFFTIME after reset");
    read_reg(`STEPPER_REG_BLANK, data);
    check_data(data, 32'd40, "BLANK after reset");
    read_reg(`STEPPER_REG_MINON, data);
    check_data(data, 32'd30, "MINON after reset");
    read_reg(`STEPPER_REG_STATUS, data);
    check_data(data, 32'h0000_0001, "STATUS after reset");
    write_readback(`STEPPER_REG_CTRL, 32'h7);
    write_readback(`STEPPER_REG_FASTDECAY, 32'h3ff);
    write_readback(`STEPPER_REG_OFFTIME, 32'h3ff);
    write_readback(`STEPPER_REG_BLANK, 32'hff);
    write_readback(`STEPPER_REG_MINON, 32'hff);
    apb_read(8'h18, data, err);
    check_flag(err, 1'b1, "pslverr on unmapped read");
    apb_write(8'h40, $urandom(), err);
    check_flag(err, 1'b1, "pslverr on unmapped write");
    apb_write(`STEPPER_REG_STATUS, 32'hffff_ffff, err);
    check_flag(err, 1'b1, "pslverr on STATUS write");
    read_status_check(1'b1);
    write_reg(`STEPPER_REG_CTRL, 32'd0);
  endtask

  task automatic test_stepping();
    int n;
    int m;
    n = $urandom_range(1, 16);
    m = $urandom_range(1, 16);
    repeat (n) do_step(1'b1);
    read_status_check(1'b1);
    repeat (m) do_step(1'b0);
    read_status_check(1'b1);
  endtask

  task automatic test_disabled_inversion();
    write_reg(`STEPPER_REG_CTRL, 32'd0);
    repeat (2) @(negedge clk);
    check_gates(read_gates(), 8'b0000_1111, "disabled");
    write_reg(`STEPPER_REG_CTRL, 32'h2);
    check_gates(read_gates(), 8'b1111_1111, "high sides inverted");
    write_reg(`STEPPER_REG_CTRL, 32'h4);
    check_gates(read_gates(), 8'b0000_0000, "low sides inverted");
    write_reg(`STEPPER_REG_CTRL, 32'h6);
    check_gates(read_gates(), 8'b1111_0000, "both sides inverted");
  endtask

  task automatic test_drive_and_sine();
    phase_t p;
    vref_t  ref_a;
    write_reg(`STEPPER_REG_CTRL, 32'h1);
    repeat (2) @(negedge clk);
    move_to(8'd0);
    check_drive("drive at phase 0");
    check_vref(vref_a, `STEPPER_SINE_PEAK, "vref_a at phase 0");
    check_vref(vref_b, 8'd0, "vref_b at phase 0");
    p = phase_t'($urandom_range(0, 255));
    move_to(p);
    check_drive("drive in first quadrant of sweep");
    ref_a = vref_a;
    move_to(p + 8'd64);
    check_drive("drive in second quadrant of sweep");
    check_vref(vref_b, ref_a, "vref_b a quarter cycle later");
    move_to(p + 8'd128);
    check_drive("drive in third quadrant of sweep");
    move_to(p + 8'd192);
    check_drive("drive in fourth quadrant of sweep");
  endtask

  task automatic test_chopping();
    int t_off;
    int thr;
    int blank;
    t_off = $urandom_range(24, 48);
    thr = t_off - $urandom_range(6, 12);
    blank = 12;
    write_reg(`STEPPER_REG_OFFTIME, apb_data_t'(t_off));
    write_reg(`STEPPER_REG_FASTDECAY, apb_data_t'(thr));
    write_reg(`STEPPER_REG_BLANK, apb_data_t'(blank));
    write_reg(`STEPPER_REG_MINON, 32'd4);
    check_drive("drive before chop");
    @(negedge clk);
    analog_cmp1 = 1'b1;
    @(negedge clk);
    analog_cmp1 = 1'b0;
    // Off timer runs from t_off down to 1, fast while at or above thr
    repeat (t_off - thr + 1) begin
      check_gates(read_gates(), expect_gates(exp_phase, FAST), "fast decay");
      @(negedge clk);
    end
    repeat (thr - 1) begin
      check_gates(read_gates(), expect_gates(exp_phase, SLOW), "slow decay");
      @(negedge clk);
    end
    repeat (blank + 4) begin
      check_drive("drive after chop");
      @(negedge clk);
    end
    check_flag(faultn, 1'b1, "faultn after a clean chop");
  endtask

  task automatic test_fault();
    int wait_cycles;
    write_reg(`STEPPER_REG_BLANK, 32'd10);
    write_reg(`STEPPER_REG_MINON, 32'd40);
    write_reg(`STEPPER_REG_OFFTIME, 32'd20);
    write_reg(`STEPPER_REG_FASTDECAY, 32'd15);
    @(negedge clk);
    analog_cmp1 = 1'b1;
    wait_cycles = 0;
    while (faultn && wait_cycles < 200) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (faultn)
      abort_run("faultn never fell while the comparator was held through blanking");
    analog_cmp1 = 1'b0;
    @(negedge clk);
    check_gates(read_gates(), 8'b0000_1111, "gates after fault");
    read_status_check(1'b0);
    apply_reset();
    exp_phase = 8'd0;
    check_flag(faultn, 1'b1, "faultn after reset");
    read_status_check(1'b1);
  endtask

  initial begin
    void'($urandom(32'hb1b4));
    resetn = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    step = 1'b0;
    dir = 1'b1;
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    exp_phase = 8'd0;
    apply_reset();
    test_register_access();
    test_stepping();
    test_disabled_inversion();
    test_drive_and_sine();
    test_chopping();
    test_fault();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: project.f
+incdir+.
stepper_pkg.sv
stepper_apb_regs.sv
phase_sequencer.sv
chopper_timer.sv
microstepper_control.sv
stepper_top.sv
tb_stepper.sv

// File: Makefile
# Verilator build and run for the stepper driver testbench

VERILATOR ?= verilator
TOP       ?= tb_stepper
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
